//--- source/ex_op_pkg.sv
////////////////////////////////////////
// Operation encodings for the execute stage
// ALU operators, multiply variants and CSR access kinds
////////////////////////////////////////
`default_nettype none

package ex_op_pkg;

  // ALU operators
  // Arithmetic and logic first, then set-less-than, then branch compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_EQ   = 4'd7,
    ALU_NE   = 4'd8,
    ALU_LT   = 4'd9,
    ALU_GE   = 4'd10,
    ALU_LTU  = 4'd11,
    ALU_GEU  = 4'd12
  } alu_op_e;

  // Multiply variants
  // MUL returns the low word, the rest return the high word
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHU  = 2'd2,
    MUL_MULHSU = 2'd3
  } mul_op_e;

  // CSR access kinds, carried on to writeback
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

endpackage

`default_nettype wire

//--- source/ex_data_pkg.sv
////////////////////////////////////////
// Data widths and word types for the execute stage
// CSR view of operand B as a packed union
////////////////////////////////////////
`default_nettype none

package ex_data_pkg;

  // Datapath widths
  localparam int unsigned WORD_W     = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned CSR_ADDR_W = 12;

  // One data word
  typedef logic [WORD_W-1:0] word_t;

  // Operand B of a CSR instruction
  // Only the low bits carry the CSR address
  typedef struct packed {
    logic [WORD_W-CSR_ADDR_W-1:0] unused;
    logic [CSR_ADDR_W-1:0]        addr;
  } csr_operand_s;

  // Operand B, decoded two ways
  // word for the ALU and multiplier, csr for a CSR access
  typedef union packed {
    word_t        word;
    csr_operand_s csr;
  } csr_operand_u;

endpackage

`default_nettype wire

//--- source/ex_alu.sv
////////////////////////////////////////
// Single-cycle ALU with shared adder
// Compare result for branches and set-less-than
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
  input  ex_op_pkg::alu_op_e  operator_i,
  input  ex_data_pkg::word_t  operand_a_i,
  input  ex_data_pkg::word_t  operand_b_i,
  output ex_data_pkg::word_t  result_o,
  output logic                cmp_result_o
);
  import ex_op_pkg::*;
  import ex_data_pkg::*;

  logic            adder_sub;
  word_t           adder_b;
  logic [WORD_W:0] adder_sum;
  logic            diff_zero;
  logic            lt_signed;
  logic            lt_unsigned;

  ////////////////////////////////////////
  // Shared adder / subtractor
  ////////////////////////////////////////

  // Every operator other than add runs the adder as a subtractor
  assign adder_sub = (operator_i != ALU_ADD);
  assign adder_b   = adder_sub ? ~operand_b_i : operand_b_i;
  // Extra top bit keeps the carry out for the unsigned compare
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{WORD_W{1'b0}}, adder_sub};

  // Compare terms derived from a - b
  assign diff_zero   = (adder_sum[WORD_W-1:0] == '0);
  // No carry out means a borrow, so a < b unsigned
  assign lt_unsigned = !adder_sum[WORD_W];
  // Different signs decide directly, else the sign of the difference
  assign lt_signed   = (operand_a_i[WORD_W-1] != operand_b_i[WORD_W-1]) ?
                       operand_a_i[WORD_W-1] : adder_sum[WORD_W-1];

  // Comparison result
  always_comb begin
    unique case (operator_i)
      ALU_SLT,  ALU_LT:  cmp_result_o = lt_signed;
      ALU_SLTU, ALU_LTU: cmp_result_o = lt_unsigned;
      ALU_EQ:            cmp_result_o = diff_zero;
      ALU_NE:            cmp_result_o = !diff_zero;
      ALU_GE:            cmp_result_o = !lt_signed;
      ALU_GEU:           cmp_result_o = !lt_unsigned;
      // Arithmetic and logic ops compare nothing
      default:           cmp_result_o = 1'b0;
    endcase
  end

  // Result word
  always_comb begin
    unique case (operator_i)
      ALU_ADD, ALU_SUB:  result_o = adder_sum[WORD_W-1:0];
      ALU_AND:           result_o = operand_a_i & operand_b_i;
      ALU_OR:            result_o = operand_a_i | operand_b_i;
      ALU_XOR:           result_o = operand_a_i ^ operand_b_i;
      // Set-less-than gives the compare bit, zero-extended
      ALU_SLT, ALU_SLTU: result_o = {{(WORD_W-1){1'b0}}, cmp_result_o};
      // Branch compares write no register
      default:           result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/ex_mult.sv
////////////////////////////////////////
// Two-cycle multiplier giving the low or high product word
// Idle/done FSM with valid/ready handshake
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ex_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_op_pkg::mul_op_e  operator_i,
  input  ex_data_pkg::word_t  op_a_i,
  input  ex_data_pkg::word_t  op_b_i,
  input  logic                valid_i,
  output logic                ready_o,
  output logic                valid_o,
  input  logic                ready_i,
  output ex_data_pkg::word_t  result_o
);
  import ex_op_pkg::*;
  import ex_data_pkg::*;

  typedef enum logic {
    MUL_IDLE = 1'b0,
    MUL_DONE = 1'b1
  } mul_state_e;

  mul_state_e                 state_q;
  mul_state_e                 state_d;
  logic                       sign_a;
  logic                       sign_b;
  logic signed [WORD_W:0]     op_a_ext;
  logic signed [WORD_W:0]     op_b_ext;
  logic signed [2*WORD_W+1:0] product_q;
  logic                       high_q;

  ////////////////////////////////////////
  // Operand extension
  ////////////////////////////////////////

  // MULH is signed by signed and MULHSU signed by unsigned
  assign sign_a = (operator_i == MUL_MULH) || (operator_i == MUL_MULHSU);
  assign sign_b = (operator_i == MUL_MULH);

  // 33 bits each so one signed multiply covers all variants
  assign op_a_ext = {sign_a & op_a_i[WORD_W-1], op_a_i};
  assign op_b_ext = {sign_b & op_b_i[WORD_W-1], op_b_i};

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Accept a request and register its product
      MUL_IDLE: if (valid_i) state_d = MUL_DONE;
      // Leave on handoff or when the request went away on a kill
      MUL_DONE: if (ready_i || !valid_i) state_d = MUL_IDLE;
      default:  state_d = MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Product and word select captured on acceptance
  always_ff @(posedge clk) begin
    if (state_q == MUL_IDLE && valid_i) begin
      product_q <= op_a_ext * op_b_ext;
      high_q    <= (operator_i != MUL_MUL);
    end
  end

  // Busy while a request is in flight in idle
  assign ready_o  = (state_q == MUL_DONE) ? ready_i : !valid_i;
  assign valid_o  = (state_q == MUL_DONE);
  assign result_o = high_q ? product_q[2*WORD_W-1:WORD_W] : product_q[WORD_W-1:0];

  // No result is ever offered from idle
  a_no_valid_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MUL_IDLE) |-> !valid_o);

endmodule

`default_nettype wire

//--- source/ex_issue_ctrl.sv
////////////////////////////////////////
// Kill/halt gating and illegality for the EX instruction
// Stage ready/valid and the result mux
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ex_issue_ctrl #(
  parameter bit HAS_MUL = 1'b1
) (
  input  logic                instr_valid_i,
  input  logic                kill_ex_i,
  input  logic                halt_ex_i,
  input  logic                alu_en_i,
  input  logic                mul_en_i,
  input  logic                csr_en_i,
  input  logic                illegal_insn_i,
  input  logic                csr_illegal_i,
  input  logic                wb_ready_i,
  input  logic                mul_ready_i,
  input  logic                mul_valid_i,
  input  ex_data_pkg::word_t  alu_result_i,
  input  ex_data_pkg::word_t  mul_result_i,
  input  ex_data_pkg::word_t  csr_rdata_i,
  output logic                mul_valid_o,
  output logic                ex_ready_o,
  output logic                ex_valid_o,
  output logic                illegal_o,
  output ex_data_pkg::word_t  rf_wdata_o
);

  logic instr_live;

  ////////////////////////////////////////
  // Instruction gating
  ////////////////////////////////////////

  // Live means valid and neither killed nor halted
  assign instr_live = instr_valid_i && !kill_ex_i && !halt_ex_i;

  // Illegal from decode, from the CSR file, or a multiply on a core without one
  assign illegal_o = instr_live &&
                     (illegal_insn_i ||
                      (csr_en_i && csr_illegal_i) ||
                      (mul_en_i && !HAS_MUL));

  // Illegal instructions never start the multiplier
  assign mul_valid_o = mul_en_i && instr_live && !illegal_o;

  ////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////

  // ALU and CSR finish in one cycle and illegal ones pass straight through
  assign ex_valid_o = instr_live &&
                      (alu_en_i ||
                       csr_en_i ||
                       (mul_en_i && mul_valid_i) ||
                       illegal_o);

  // Kill frees the stage at once
  // Otherwise wait for writeback and the multiplier unless halted
  assign ex_ready_o = kill_ex_i || (wb_ready_i && mul_ready_i && !halt_ex_i);

  // Register write data from the unit in use
  always_comb begin
    unique case (1'b1)
      alu_en_i: rf_wdata_o = alu_result_i;
      mul_en_i: rf_wdata_o = mul_result_i;
      csr_en_i: rf_wdata_o = csr_rdata_i;
      default:  rf_wdata_o = alu_result_i;
    endcase
  end

  // Decode steers each instruction to at most one unit
  always_comb begin
    if (instr_valid_i) begin
      a_unit_onehot: assert ($onehot0({alu_en_i, mul_en_i, csr_en_i}));
    end
  end

endmodule

`default_nettype wire

//--- source/ex_wb_reg.sv
////////////////////////////////////////
// EX/WB pipeline register
// Bubble insertion and CSR field capture
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ex_wb_reg (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                ex_valid_i,
  input  logic                                wb_ready_i,
  input  logic                                rf_we_i,
  input  logic [ex_data_pkg::REG_ADDR_W-1:0]  rf_waddr_i,
  input  ex_data_pkg::word_t                  rf_wdata_i,
  input  logic                                illegal_i,
  input  logic                                csr_en_i,
  input  ex_op_pkg::csr_op_e                  csr_op_i,
  input  ex_data_pkg::csr_operand_u           csr_operand_i,
  input  ex_data_pkg::word_t                  csr_wdata_i,
  input  logic                                alu_bch_i,
  input  logic                                alu_en_i,
  input  logic                                cmp_result_i,
  output logic                                wb_instr_valid_o,
  output logic                                wb_rf_we_o,
  output logic [ex_data_pkg::REG_ADDR_W-1:0]  wb_rf_waddr_o,
  output ex_data_pkg::word_t                  wb_rf_wdata_o,
  output logic                                wb_csr_en_o,
  output ex_op_pkg::csr_op_e                  wb_csr_op_o,
  output logic [ex_data_pkg::CSR_ADDR_W-1:0]  wb_csr_addr_o,
  output ex_data_pkg::word_t                  wb_csr_wdata_o,
  output logic                                wb_illegal_insn_o,
  output logic                                wb_bch_taken_o
);
  import ex_op_pkg::*;

  logic xfer;

  // Instruction moves to WB on this edge
  assign xfer = ex_valid_i && wb_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_instr_valid_o  <= 1'b0;
      wb_rf_we_o        <= 1'b0;
      wb_rf_waddr_o     <= '0;
      wb_rf_wdata_o     <= '0;
      wb_csr_en_o       <= 1'b0;
      wb_csr_op_o       <= CSR_OP_READ;
      wb_csr_addr_o     <= '0;
      wb_csr_wdata_o    <= '0;
      wb_illegal_insn_o <= 1'b0;
      wb_bch_taken_o    <= 1'b0;
    end else if (xfer) begin
      wb_instr_valid_o  <= 1'b1;
      // Illegal instructions touch neither the register file nor the CSRs
      wb_rf_we_o        <= illegal_i ? 1'b0 : rf_we_i;
      wb_csr_en_o       <= illegal_i ? 1'b0 : csr_en_i;
      wb_illegal_insn_o <= illegal_i;
      // Taken only for a real branch on the ALU
      wb_bch_taken_o    <= alu_bch_i && alu_en_i && cmp_result_i;

      // Write fields only move for a register write
      if (rf_we_i) begin
        wb_rf_waddr_o <= rf_waddr_i;
        wb_rf_wdata_o <= rf_wdata_i;
      end

      // CSR address comes from the CSR view of operand B
      if (csr_en_i) begin
        wb_csr_op_o    <= csr_op_i;
        wb_csr_addr_o  <= csr_operand_i.csr.addr;
        wb_csr_wdata_o <= csr_wdata_i;
      end
    end else if (wb_ready_i) begin
      // WB takes a slot but EX has nothing, so a bubble
      wb_instr_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/ex_stage.sv
////////////////////////////////////////
// Execute stage top level
// ALU, optional multiplier, issue control, EX/WB register
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ex_stage #(
  parameter bit HAS_MUL = 1'b1
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // ID/EX fields
  input  logic                                instr_valid_i,
  input  logic                                alu_en_i,
  input  logic                                mul_en_i,
  input  logic                                csr_en_i,
  input  logic                                rf_we_i,
  input  logic [ex_data_pkg::REG_ADDR_W-1:0]  rf_waddr_i,
  input  ex_op_pkg::alu_op_e                  alu_op_i,
  input  logic                                alu_bch_i,
  input  ex_op_pkg::mul_op_e                  mul_op_i,
  input  ex_op_pkg::csr_op_e                  csr_op_i,
  input  ex_data_pkg::word_t                  operand_a_i,
  input  ex_data_pkg::csr_operand_u           operand_b_i,
  input  logic                                illegal_insn_i,
  // Controller
  input  logic                                kill_ex_i,
  input  logic                                halt_ex_i,
  // CSR file
  input  ex_data_pkg::word_t                  csr_rdata_i,
  input  logic                                csr_illegal_i,
  // Writeback back-pressure
  input  logic                                wb_ready_i,
  // Stage handshake and forwarding
  output logic                                ex_ready_o,
  output logic                                ex_valid_o,
  output ex_data_pkg::word_t                  rf_wdata_o,
  output logic                                branch_decision_o,
  // EX/WB register
  output logic                                wb_instr_valid_o,
  output logic                                wb_rf_we_o,
  output logic [ex_data_pkg::REG_ADDR_W-1:0]  wb_rf_waddr_o,
  output ex_data_pkg::word_t                  wb_rf_wdata_o,
  output logic                                wb_csr_en_o,
  output ex_op_pkg::csr_op_e                  wb_csr_op_o,
  output logic [ex_data_pkg::CSR_ADDR_W-1:0]  wb_csr_addr_o,
  output ex_data_pkg::word_t                  wb_csr_wdata_o,
  output logic                                wb_illegal_insn_o,
  output logic                                wb_bch_taken_o
);
  import ex_data_pkg::*;

  word_t alu_result;
  word_t mul_result;
  logic  mul_req;
  logic  mul_ready;
  logic  mul_valid;
  logic  illegal;

  ////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////

  // Compare bit doubles as the branch decision
  ex_alu alu_inst (
    .operator_i   (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i.word),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  generate
    if (HAS_MUL) begin : gen_mul
      ex_mult mult_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .operator_i (mul_op_i),
        .op_a_i     (operand_a_i),
        .op_b_i     (operand_b_i.word),
        .valid_i    (mul_req),
        .ready_o    (mul_ready),
        .valid_o    (mul_valid),
        .ready_i    (wb_ready_i),
        .result_o   (mul_result)
      );
    end else begin : gen_no_mul
      // Always ready, never valid
      assign mul_ready  = 1'b1;
      assign mul_valid  = 1'b0;
      assign mul_result = '0;
    end
  endgenerate

  ////////////////////////////////////////
  // Issue control and EX/WB register
  ////////////////////////////////////////

  ex_issue_ctrl #(
    .HAS_MUL (HAS_MUL)
  ) issue_ctrl_inst (
    .instr_valid_i  (instr_valid_i),
    .kill_ex_i      (kill_ex_i),
    .halt_ex_i      (halt_ex_i),
    .alu_en_i       (alu_en_i),
    .mul_en_i       (mul_en_i),
    .csr_en_i       (csr_en_i),
    .illegal_insn_i (illegal_insn_i),
    .csr_illegal_i  (csr_illegal_i),
    .wb_ready_i     (wb_ready_i),
    .mul_ready_i    (mul_ready),
    .mul_valid_i    (mul_valid),
    .alu_result_i   (alu_result),
    .mul_result_i   (mul_result),
    .csr_rdata_i    (csr_rdata_i),
    .mul_valid_o    (mul_req),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o),
    .illegal_o      (illegal),
    .rf_wdata_o     (rf_wdata_o)
  );

  // CSR write data is operand A
  ex_wb_reg wb_reg_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .ex_valid_i        (ex_valid_o),
    .wb_ready_i        (wb_ready_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .rf_wdata_i        (rf_wdata_o),
    .illegal_i         (illegal),
    .csr_en_i          (csr_en_i),
    .csr_op_i          (csr_op_i),
    .csr_operand_i     (operand_b_i),
    .csr_wdata_i       (operand_a_i),
    .alu_bch_i         (alu_bch_i),
    .alu_en_i          (alu_en_i),
    .cmp_result_i      (branch_decision_o),
    .wb_instr_valid_o  (wb_instr_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_csr_en_o       (wb_csr_en_o),
    .wb_csr_op_o       (wb_csr_op_o),
    .wb_csr_addr_o     (wb_csr_addr_o),
    .wb_csr_wdata_o    (wb_csr_wdata_o),
    .wb_illegal_insn_o (wb_illegal_insn_o),
    .wb_bch_taken_o    (wb_bch_taken_o)
  );

endmodule

`default_nettype wire

//--- verification/ex_stage_vectors.svh
////////////////////////////////////////
// Stimulus and expected-value table for the EX stage
// One row per instruction, applied in order
////////////////////////////////////////
`ifndef EX_STAGE_VECTORS_SVH
`define EX_STAGE_VECTORS_SVH

// Row layout
// name | alu mul csr | op | bch rnd | a b | we waddr | csr_rdata | csr_ill ill kill
// halt stall | exp wdata we csr_en csr_addr ill bch
typedef struct {
  string       name;
  bit          alu_en;
  bit          mul_en;
  bit          csr_en;
  bit [3:0]    op;
  bit          bch;
  bit          rnd;
  logic [31:0] a;
  logic [31:0] b;
  bit          rf_we;
  bit [4:0]    waddr;
  logic [31:0] csr_rdata;
  bit          csr_ill;
  bit          ill;
  bit          kill;
  int          halt_cyc;
  int          stall_cyc;
  logic [31:0] exp_wdata;
  bit          exp_we;
  bit          exp_csr_en;
  bit [11:0]   exp_csr_addr;
  bit          exp_ill;
  bit          exp_bch;
} vec_t;

localparam int NUM_VEC = 27;

vec_t vectors [NUM_VEC] = '{
  // ALU arithmetic and logic
  '{"add", 1, 0, 0, ALU_ADD, 0, 0, 32'h0000_1234, 32'h0000_5678, 1, 5'd1, 32'h0, 0, 0, 0,
    0, 0, 32'h0000_68AC, 1, 0, 12'h000, 0, 0},
  '{"sub", 1, 0, 0, ALU_SUB, 0, 0, 32'h0000_0005, 32'h0000_0007, 1, 5'd2, 32'h0, 0, 0, 0,
    0, 0, 32'hFFFF_FFFE, 1, 0, 12'h000, 0, 0},
  '{"and", 1, 0, 0, ALU_AND, 0, 0, 32'hF0F0_F0F0, 32'hFF00_FF00, 1, 5'd3, 32'h0, 0, 0, 0,
    0, 0, 32'hF000_F000, 1, 0, 12'h000, 0, 0},
  '{"or", 1, 0, 0, ALU_OR, 0, 0, 32'hF0F0_F0F0, 32'hFF00_FF00, 1, 5'd4, 32'h0, 0, 0, 0,
    0, 0, 32'hFFF0_FFF0, 1, 0, 12'h000, 0, 0},
  '{"xor", 1, 0, 0, ALU_XOR, 0, 0, 32'hF0F0_F0F0, 32'hFF00_FF00, 1, 5'd5, 32'h0, 0, 0, 0,
    0, 0, 32'h0FF0_0FF0, 1, 0, 12'h000, 0, 0},
  '{"slt", 1, 0, 0, ALU_SLT, 0, 0, 32'hFFFF_FFFF, 32'h0000_0001, 1, 5'd6, 32'h0, 0, 0, 0,
    0, 0, 32'h0000_0001, 1, 0, 12'h000, 0, 0},
  '{"sltu", 1, 0, 0, ALU_SLTU, 0, 0, 32'hFFFF_FFFF, 32'h0000_0001, 1, 5'd7, 32'h0, 0, 0, 0,
    0, 0, 32'h0000_0000, 1, 0, 12'h000, 0, 0},
  // Branch compares, no register write
  '{"beq", 1, 0, 0, ALU_EQ, 1, 0, 32'h0000_0055, 32'h0000_0055, 0, 5'd8, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 0, 0, 12'h000, 0, 1},
  '{"bne", 1, 0, 0, ALU_NE, 1, 0, 32'h0000_0055, 32'h0000_0055, 0, 5'd8, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 0, 0, 12'h000, 0, 0},
  '{"blt", 1, 0, 0, ALU_LT, 1, 0, 32'h8000_0000, 32'h0000_0001, 0, 5'd8, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 0, 0, 12'h000, 0, 1},
  '{"bge", 1, 0, 0, ALU_GE, 1, 0, 32'h8000_0000, 32'h0000_0001, 0, 5'd8, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 0, 0, 12'h000, 0, 0},
  '{"bltu", 1, 0, 0, ALU_LTU, 1, 0, 32'h8000_0000, 32'h0000_0001, 0, 5'd8, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 0, 0, 12'h000, 0, 0},
  '{"bgeu", 1, 0, 0, ALU_GEU, 1, 0, 32'h8000_0000, 32'h0000_0001, 0, 5'd8, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 0, 0, 12'h000, 0, 1},
  // Multiply variants
  '{"mul", 0, 1, 0, 4'(MUL_MUL), 0, 0, 32'h0000_0007, 32'h0000_0006, 1, 5'd9, 32'h0, 0, 0,
    0, 0, 0, 32'h0000_002A, 1, 0, 12'h000, 0, 0},
  '{"mulh", 0, 1, 0, 4'(MUL_MULH), 0, 0, 32'hFFFF_FFFE, 32'h0000_0003, 1, 5'd10, 32'h0, 0,
    0, 0, 0, 0, 32'hFFFF_FFFF, 1, 0, 12'h000, 0, 0},
  '{"mulhu", 0, 1, 0, 4'(MUL_MULHU), 0, 0, 32'hFFFF_FFFE, 32'h0000_0003, 1, 5'd11, 32'h0, 0,
    0, 0, 0, 0, 32'h0000_0002, 1, 0, 12'h000, 0, 0},
  '{"mulhsu", 0, 1, 0, 4'(MUL_MULHSU), 0, 0, 32'hFFFF_FFFE, 32'h8000_0000, 1, 5'd12, 32'h0,
    0, 0, 0, 0, 0, 32'hFFFF_FFFF, 1, 0, 12'h000, 0, 0},
  // CSR access, legal then rejected by the CSR file
  '{"csr", 0, 0, 1, 4'(CSR_OP_SET), 0, 0, 32'h0000_000F, 32'hABCD_1305, 1, 5'd13,
    32'h0000_1800, 0, 0, 0, 0, 0, 32'h0000_1800, 1, 1, 12'h305, 0, 0},
  '{"csr_illegal", 0, 0, 1, 4'(CSR_OP_WRITE), 0, 0, 32'h0000_00A5, 32'h0000_0342, 1, 5'd14,
    32'h0000_7777, 1, 0, 0, 0, 0, 32'h0, 0, 0, 12'h342, 1, 0},
  // Decode-illegal, kill, halt and back-pressure
  '{"illegal", 1, 0, 0, ALU_ADD, 0, 0, 32'h0000_0001, 32'h0000_0001, 1, 5'd15, 32'h0, 0, 1,
    0, 0, 0, 32'h0, 0, 0, 12'h000, 1, 0},
  '{"kill", 1, 0, 0, ALU_ADD, 0, 0, 32'h0000_0001, 32'h0000_0002, 1, 5'd16, 32'h0, 0, 0, 1,
    0, 0, 32'h0, 0, 0, 12'h000, 0, 0},
  '{"halt", 1, 0, 0, ALU_ADD, 0, 0, 32'h0000_0003, 32'h0000_0004, 1, 5'd17, 32'h0, 0, 0, 0,
    3, 0, 32'h0000_0007, 1, 0, 12'h000, 0, 0},
  '{"stall", 1, 0, 0, ALU_XOR, 0, 0, 32'h0000_FFFF, 32'h00FF_00FF, 1, 5'd18, 32'h0, 0, 0, 0,
    0, 3, 32'h00FF_FF00, 1, 0, 12'h000, 0, 0},
  // Operands from the LFSR, expected values worked out at run time
  '{"rnd_add", 1, 0, 0, ALU_ADD, 0, 1, 32'h0, 32'h0, 1, 5'd19, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 1, 0, 12'h000, 0, 0},
  '{"rnd_sub", 1, 0, 0, ALU_SUB, 0, 1, 32'h0, 32'h0, 1, 5'd20, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 1, 0, 12'h000, 0, 0},
  '{"rnd_sltu", 1, 0, 0, ALU_SLTU, 0, 1, 32'h0, 32'h0, 1, 5'd21, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 1, 0, 12'h000, 0, 0},
  '{"rnd_blt", 1, 0, 0, ALU_LT, 1, 1, 32'h0, 32'h0, 0, 5'd22, 32'h0, 0, 0, 0,
    0, 0, 32'h0, 0, 0, 12'h000, 0, 0}
};

`endif

//--- verification/tb_ex_stage.sv
////////////////////////////////////////
// Testbench for the EX stage
// Table-driven rows, LFSR operands, timeout
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage;
  import ex_op_pkg::*;
  import ex_data_pkg::*;

  `include "ex_stage_vectors.svh"

  localparam int TIMEOUT_CYCLES = NUM_VEC * 8 + 100;

  logic         clk;
  logic         rst_n;
  logic         instr_valid, alu_en, mul_en, csr_en, rf_we, alu_bch;
  logic [4:0]   rf_waddr;
  alu_op_e      alu_op;
  mul_op_e      mul_op;
  csr_op_e      csr_op;
  word_t        operand_a;
  csr_operand_u operand_b;
  logic         illegal_insn, kill_ex, halt_ex, csr_illegal, wb_ready;
  word_t        csr_rdata;
  logic         ex_ready, ex_valid, branch_decision;
  word_t        rf_wdata;
  logic         wb_instr_valid, wb_rf_we, wb_csr_en, wb_illegal_insn, wb_bch_taken;
  logic [4:0]   wb_rf_waddr;
  word_t        wb_rf_wdata, wb_csr_wdata;
  csr_op_e      wb_csr_op;
  logic [11:0]  wb_csr_addr;

  int           errors;
  int           cycle_count;
  logic [15:0]  lfsr_q;

  ex_stage #(.HAS_MUL(1'b1)) ex_stage_inst (
    .clk(clk), .rst_n(rst_n),
    .instr_valid_i(instr_valid), .alu_en_i(alu_en), .mul_en_i(mul_en), .csr_en_i(csr_en),
    .rf_we_i(rf_we), .rf_waddr_i(rf_waddr), .alu_op_i(alu_op), .alu_bch_i(alu_bch),
    .mul_op_i(mul_op), .csr_op_i(csr_op), .operand_a_i(operand_a), .operand_b_i(operand_b),
    .illegal_insn_i(illegal_insn), .kill_ex_i(kill_ex), .halt_ex_i(halt_ex),
    .csr_rdata_i(csr_rdata), .csr_illegal_i(csr_illegal), .wb_ready_i(wb_ready),
    .ex_ready_o(ex_ready), .ex_valid_o(ex_valid), .rf_wdata_o(rf_wdata),
    .branch_decision_o(branch_decision),
    .wb_instr_valid_o(wb_instr_valid), .wb_rf_we_o(wb_rf_we), .wb_rf_waddr_o(wb_rf_waddr),
    .wb_rf_wdata_o(wb_rf_wdata), .wb_csr_en_o(wb_csr_en), .wb_csr_op_o(wb_csr_op),
    .wb_csr_addr_o(wb_csr_addr), .wb_csr_wdata_o(wb_csr_wdata),
    .wb_illegal_insn_o(wb_illegal_insn), .wb_bch_taken_o(wb_bch_taken)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // Watchdog on the total run length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no handshake after %0d cycles", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Compare one value and report a mismatch
  task automatic check_val(input string test, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test, field, exp, act);
    end
  endtask

  // Fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit taken
  function automatic logic [31:0] rand_word();
    logic        fb;
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < 32; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      word   = {word[30:0], fb};
    end
    return word;
  endfunction

  // Reference ALU with the result in the low word and the compare in bit 32
  function automatic logic [32:0] alu_ref(input bit [3:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic cmp;
    logic [31:0] res;
    cmp = 1'b0;
    res = 32'h0;
    case (op)
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a - b;
      ALU_AND:  res = a & b;
      ALU_OR:   res = a | b;
      ALU_XOR:  res = a ^ b;
      ALU_SLT: begin
        cmp = ($signed(a) < $signed(b));
        res = {31'h0, cmp};
      end
      ALU_SLTU: begin
        cmp = (a < b);
        res = {31'h0, cmp};
      end
      ALU_EQ:   cmp = (a == b);
      ALU_NE:   cmp = (a != b);
      ALU_LT:   cmp = ($signed(a) < $signed(b));
      ALU_GE:   cmp = ($signed(a) >= $signed(b));
      ALU_LTU:  cmp = (a < b);
      ALU_GEU:  cmp = (a >= b);
      default:  res = 32'h0;
    endcase
    return {cmp, res};
  endfunction

  // Drive one row, wait for the handshake and check writeback
  task automatic apply_row(input vec_t v);
    logic [32:0] ref_out;
    logic [31:0] held_wdata;
    logic        held_valid;
    if (v.rnd) begin
      v.a         = rand_word();
      v.b         = rand_word();
      ref_out     = alu_ref(v.op, v.a, v.b);
      v.exp_wdata = ref_out[31:0];
      v.exp_bch   = v.bch & ref_out[32];
    end
    instr_valid    = 1'b1;
    alu_en         = v.alu_en;
    mul_en         = v.mul_en;
    csr_en         = v.csr_en;
    alu_op         = alu_op_e'(v.op);
    mul_op         = mul_op_e'(v.op[1:0]);
    csr_op         = csr_op_e'(v.op[1:0]);
    alu_bch        = v.bch;
    operand_a      = v.a;
    operand_b.word = v.b;
    rf_we          = v.rf_we;
    rf_waddr       = v.waddr;
    csr_rdata      = v.csr_rdata;
    csr_illegal    = v.csr_ill;
    illegal_insn   = v.ill;
    kill_ex        = v.kill;
    halt_ex        = (v.halt_cyc > 0);
    wb_ready       = (v.stall_cyc == 0);
    #1;
    // Killed row frees the stage and leaves a bubble
    if (v.kill) begin
      check_val(v.name, "ex_ready", 1, ex_ready);
      check_val(v.name, "ex_valid", 0, ex_valid);
      @(posedge clk);
      #0.5;
      instr_valid = 1'b0;
      kill_ex     = 1'b0;
      check_val(v.name, "wb_instr_valid", 0, wb_instr_valid);
      return;
    end
    // Halted row holds the stage
    for (int i = 0; i < v.halt_cyc; i++) begin
      check_val(v.name, "ex_ready", 0, ex_ready);
      check_val(v.name, "ex_valid", 0, ex_valid);
      @(posedge clk);
      #0.5;
      if (i == v.halt_cyc - 1) halt_ex = 1'b0;
      #1;
    end
    // WB outputs hold while writeback stalls
    for (int i = 0; i < v.stall_cyc; i++) begin
      held_wdata = wb_rf_wdata;
      held_valid = wb_instr_valid;
      check_val(v.name, "ex_ready", 0, ex_ready);
      @(posedge clk);
      #0.5;
      check_val(v.name, "held wb_rf_wdata", held_wdata, wb_rf_wdata);
      check_val(v.name, "held wb_instr_valid", held_valid, wb_instr_valid);
      if (i == v.stall_cyc - 1) wb_ready = 1'b1;
      #1;
    end
    // No multiply result is offered in the issue cycle
    if (v.mul_en) begin
      check_val(v.name, "ex_valid issue", 0, ex_valid);
      check_val(v.name, "ex_ready issue", 0, ex_ready);
      @(posedge clk);
      #1.5;
      check_val(v.name, "ex_valid second", 1, ex_valid);
    end
    while (!(ex_valid === 1'b1 && wb_ready === 1'b1)) begin
      @(posedge clk);
      #1.5;
    end
    // Combinational outputs in the handshake cycle
    if (v.exp_we) check_val(v.name, "rf_wdata", v.exp_wdata, rf_wdata);
    if (v.bch) check_val(v.name, "branch_decision", v.exp_bch, branch_decision);
    @(posedge clk);
    #0.5;
    instr_valid = 1'b0;
    check_val(v.name, "wb_instr_valid", 1, wb_instr_valid);
    check_val(v.name, "wb_rf_we", v.exp_we, wb_rf_we);
    check_val(v.name, "wb_csr_en", v.exp_csr_en, wb_csr_en);
    check_val(v.name, "wb_illegal_insn", v.exp_ill, wb_illegal_insn);
    check_val(v.name, "wb_bch_taken", v.exp_bch, wb_bch_taken);
    if (v.exp_we) begin
      check_val(v.name, "wb_rf_wdata", v.exp_wdata, wb_rf_wdata);
      check_val(v.name, "wb_rf_waddr", v.waddr, wb_rf_waddr);
    end
    if (v.csr_en) begin
      check_val(v.name, "wb_csr_addr", v.exp_csr_addr, wb_csr_addr);
      check_val(v.name, "wb_csr_wdata", v.a, wb_csr_wdata);
      check_val(v.name, "wb_csr_op", v.op[1:0], wb_csr_op);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    instr_valid  = 1'b0;
    alu_en       = 1'b0;
    mul_en       = 1'b0;
    csr_en       = 1'b0;
    rf_we        = 1'b0;
    rf_waddr     = '0;
    alu_op       = ALU_ADD;
    alu_bch      = 1'b0;
    mul_op       = MUL_MUL;
    csr_op       = CSR_OP_READ;
    operand_a    = '0;
    operand_b    = '0;
    illegal_insn = 1'b0;
    kill_ex      = 1'b0;
    halt_ex      = 1'b0;
    csr_rdata    = '0;
    csr_illegal  = 1'b0;
    wb_ready     = 1'b1;
    errors       = 0;
    cycle_count  = 0;
    lfsr_q       = 16'd38;

    repeat (16) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    // Reset values
    check_val("reset", "wb_instr_valid", 0, wb_instr_valid);
    check_val("reset", "wb_csr_op", CSR_OP_READ, wb_csr_op);

    for (int i = 0; i < NUM_VEC; i++) begin
      apply_row(vectors[i]);
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ex_stage.f
+incdir+verification
source/ex_op_pkg.sv
source/ex_data_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_issue_ctrl.sv
source/ex_wb_reg.sv
source/ex_stage.sv
verification/tb_ex_stage.sv

//--- Makefile
TB_TOP := tb_ex_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TB_TOP) -f ex_stage.f

run: build
	./obj_dir/V$(TB_TOP) | tee /dev/stderr | grep -q "Regression passed"

lint:
	verilator --lint-only --timing --top-module ex_stage -f ex_stage.f

clean:
	rm -rf obj_dir
